//--- include/memInit.svh
localparam word_t MEM_INIT_VALUES [INIT_WORDS] = '{  // Start-up contents of words 0 to 31.
    32'hAAAA_AAAA,  // Word 0.
    32'hCCCC_CCCC,
    32'hF0F0_F0F0,
    32'h0F0F_0F0F,
    32'h3333_3333,  // Word 4.
    32'h5555_5555,
    32'h9999_9999,
    32'h6666_6666,
    32'h0000_FFFF,  // Word 8.
    32'hFFFF_0000,
    32'h8000_8001,
    32'h7FFF_7FFE,
    32'h4204_4204,  // Word 12.
    32'h1111_1111,
    32'hE38E_E38E,
    32'hAABA_AABA,
    32'h8040_8040,  // Word 16.
    32'h7FBF_7FBF,
    32'h2C2C_2C2C,
    32'hD3D3_D3D3,
    32'h5A5A_5A5A,  // Word 20.
    32'h3C3C_3C3C,
    32'hFC0F_03F0,
    32'h0FF0_F00F,
    32'hA8A8_A8A8,  // Word 24.
    32'h5757_5757,
    32'hCF33_CCCC,
    32'h330C_330C,
    32'h6969_6969,  // Word 28.
    32'h9696_9696,
    32'h03F0_07E0,
    32'hE00F_E00F   // Word 31.
};

//--- hw/dataMemPkg.sv
`default_nettype none

package dataMemPkg;

    typedef logic [31:0] word_t;  // Data word moved by loads and stores.
    typedef logic [31:0] addr_t;  // Byte address as issued by the core.

    // Memory geometry.
    localparam int MEM_WORDS   = 256;
    localparam int MEM_INDEX_W = $clog2(MEM_WORDS);
    localparam int ADDR_LSB    = 2;  // Byte offset bits below the word index.
    localparam int INIT_WORDS  = 32;  // Words preloaded from memInit.svh.

    // Requesting ports.
    localparam int NUM_PORTS  = 2;
    localparam int PORT_IDX_W = $clog2(NUM_PORTS);

    // Per-port request queue, also the credit count after reset.
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

endpackage

`default_nettype wire

//--- hw/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory
    import dataMemPkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   memEn,
    input  wire logic                   memWrite,
    input  wire logic [MEM_INDEX_W-1:0] memIndex,
    input  word_t                       memWdata,
    output word_t                       memRdata
);

    `include "memInit.svh"

    word_t mem [MEM_WORDS];  // Word array, one entry per index.

    // Low words get their fixed values, the rest start cleared.
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (i < INIT_WORDS) begin
                mem[i] = MEM_INIT_VALUES[i];
            end else begin
                mem[i] = '0;
            end
        end
    end

    // Single port. A store writes at the edge, a load registers the word.
    always @(posedge clk) begin
        if (memEn) begin
            if (memWrite) begin
                mem[memIndex] <= memWdata;
            end else begin
                memRdata <= mem[memIndex];  // Valid the cycle after the grant.
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/memArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memArbiter
    import dataMemPkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   headValid [NUM_PORTS],
    input  wire logic                   headWrite [NUM_PORTS],
    input  addr_t                       headAddr  [NUM_PORTS],
    input  word_t                       headWdata [NUM_PORTS],
    output logic                        grant     [NUM_PORTS],
    output logic                        memEn,
    output logic                        memWrite,
    output logic      [MEM_INDEX_W-1:0] memIndex,
    output word_t                       memWdata,
    input  word_t                       memRdata,
    output logic                        respValid [NUM_PORTS],
    output word_t                       respData  [NUM_PORTS]
);

    logic [PORT_IDX_W-1:0] lastGrant;    // Port that won most recently.
    logic [PORT_IDX_W-1:0] winner;       // Port chosen this cycle.
    logic                  anyValid;     // Some head is waiting.
    logic                  loadPending;  // Read data arrives this cycle.
    logic [PORT_IDX_W-1:0] loadPort;     // Owner of that read data.

    // Walk from the port after lastGrant. The closest valid head wins,
    // so the scan runs backwards and the last hit has the highest priority.
    always_comb begin
        int idx;
        winner   = lastGrant;
        anyValid = 1'b0;
        for (int k = NUM_PORTS; k >= 1; k--) begin
            idx = (int'(lastGrant) + k) % NUM_PORTS;
            if (headValid[idx]) begin
                winner   = PORT_IDX_W'(idx);
                anyValid = 1'b1;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            grant[p] = anyValid && (winner == PORT_IDX_W'(p));
        end
    end

    // Winner's request drives the memory port.
    assign memEn    = anyValid;
    assign memWrite = headWrite[winner];
    assign memIndex = headAddr[winner][ADDR_LSB +: MEM_INDEX_W];  // Bits 9:2.
    assign memWdata = headWdata[winner];

    always_ff @(posedge clk) begin
        if (rst) begin
            lastGrant   <= PORT_IDX_W'(NUM_PORTS - 1);  // Port 0 wins first.
            loadPending <= 1'b0;
            loadPort    <= '0;
        end else begin
            if (anyValid) begin
                lastGrant <= winner;
            end
            loadPending <= anyValid && !headWrite[winner];
            loadPort    <= winner;
        end
    end

    // Read data goes to every port, only the owner sees respValid.
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            respValid[p] = loadPending && (loadPort == PORT_IDX_W'(p));
            respData[p]  = memRdata;
        end
    end

endmodule

`default_nettype wire

//--- hw/loadStoreQueue.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreQueue
    import dataMemPkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic reqValid,
    input  wire logic reqWrite,
    input  addr_t     reqAddr,
    input  word_t     reqWdata,
    input  wire logic grant,
    output logic      headValid,
    output logic      headWrite,
    output addr_t     headAddr,
    output word_t     headWdata,
    output logic      creditReturn
);

    // Entry storage, one slot per credit.
    logic  entryWrite [QUEUE_DEPTH];
    addr_t entryAddr  [QUEUE_DEPTH];
    word_t entryWdata [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0] wrPtr;      // Next free slot.
    logic [QUEUE_PTR_W-1:0] rdPtr;      // Current head.
    logic [QUEUE_CNT_W-1:0] fillCount;  // Occupied slots.
    logic                   push;
    logic                   pop;

    // Credits keep the requester from pushing into a full queue.
    assign push = reqValid;
    assign pop  = grant && headValid;

    // The grant cycle is the pop, and the freed slot goes back as a credit.
    assign creditReturn = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            entryWrite[wrPtr] <= reqWrite;
            entryAddr[wrPtr]  <= reqAddr;
            entryWdata[wrPtr] <= reqWdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            fillCount <= '0;
        end else begin
            if (push) begin
                if (wrPtr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) begin
                    wrPtr <= '0;
                end else begin
                    wrPtr <= wrPtr + 1'b1;
                end
            end
            if (pop) begin
                if (rdPtr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) begin
                    rdPtr <= '0;
                end else begin
                    rdPtr <= rdPtr + 1'b1;
                end
            end
            // Simultaneous push and pop leave the count unchanged.
            case ({push, pop})
                2'b10:   fillCount <= fillCount + 1'b1;
                2'b01:   fillCount <= fillCount - 1'b1;
                default: fillCount <= fillCount;
            endcase
        end
    end

    // Head entry as seen by the arbiter.
    assign headValid = (fillCount != '0);
    assign headWrite = entryWrite[rdPtr];
    assign headAddr  = entryAddr[rdPtr];
    assign headWdata = entryWdata[rdPtr];

endmodule

`default_nettype wire

//--- hw/dataMemSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemSubsystem
    import dataMemPkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic reqValid     [NUM_PORTS],
    input  wire logic reqWrite     [NUM_PORTS],
    input  addr_t     reqAddr      [NUM_PORTS],
    input  word_t     reqWdata     [NUM_PORTS],
    output logic      creditReturn [NUM_PORTS],
    output logic      respValid    [NUM_PORTS],
    output word_t     respData     [NUM_PORTS]
);

    // Queue heads toward the arbiter.
    logic  headValid [NUM_PORTS];
    logic  headWrite [NUM_PORTS];
    addr_t headAddr  [NUM_PORTS];
    word_t headWdata [NUM_PORTS];
    logic  grant     [NUM_PORTS];

    // Arbiter to memory.
    logic                   memEn;
    logic                   memWrite;
    logic [MEM_INDEX_W-1:0] memIndex;
    word_t                  memWdata;
    word_t                  memRdata;

    // One request queue per port.
    for (genvar p = 0; p < NUM_PORTS; p++) begin : gPort
        loadStoreQueue u_queue (
            .clk          (clk),
            .rst          (rst),
            .reqValid     (reqValid[p]),
            .reqWrite     (reqWrite[p]),
            .reqAddr      (reqAddr[p]),
            .reqWdata     (reqWdata[p]),
            .grant        (grant[p]),
            .headValid    (headValid[p]),
            .headWrite    (headWrite[p]),
            .headAddr     (headAddr[p]),
            .headWdata    (headWdata[p]),
            .creditReturn (creditReturn[p])
        );
    end

    memArbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .headValid (headValid),
        .headWrite (headWrite),
        .headAddr  (headAddr),
        .headWdata (headWdata),
        .grant     (grant),
        .memEn     (memEn),
        .memWrite  (memWrite),
        .memIndex  (memIndex),
        .memWdata  (memWdata),
        .memRdata  (memRdata),
        .respValid (respValid),
        .respData  (respData)
    );

    dataMemory u_memory (
        .clk      (clk),
        .memEn    (memEn),
        .memWrite (memWrite),
        .memIndex (memIndex),
        .memWdata (memWdata),
        .memRdata (memRdata)
    );

endmodule

`default_nettype wire

//--- verif/memChecker.sv
`timescale 1ns/1ps
`default_nettype none

module memChecker
    import dataMemPkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic reqValid     [NUM_PORTS],
    input  wire logic reqWrite     [NUM_PORTS],
    input  addr_t     reqAddr      [NUM_PORTS],
    input  word_t     reqWdata     [NUM_PORTS],
    input  wire logic creditReturn [NUM_PORTS],
    input  wire logic respValid    [NUM_PORTS],
    input  word_t     respData     [NUM_PORTS],
    output int        errorCount,
    output int        creditTotal,
    output logic      drained
);

    `include "memInit.svh"

    word_t model [MEM_WORDS];  // Reference memory contents.

    // Requests sent but not yet granted, oldest first.
    logic  outWrite [NUM_PORTS][$];
    addr_t outAddr  [NUM_PORTS][$];
    word_t outWdata [NUM_PORTS][$];

    word_t pendData    [NUM_PORTS][$];  // Expected load data in grant order.
    logic  loadGranted [NUM_PORTS];     // Load credit seen on the last falling edge.
    int    errors  = 0;
    int    credits = 0;

    assign errorCount  = errors;
    assign creditTotal = credits;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            model[i] = (i < INIT_WORDS) ? MEM_INIT_VALUES[i] : '0;
        end
    end

    // Bits 9:2 pick the word and all other address bits are ignored.
    function automatic word_t refLoad(input addr_t addr);
        return model[addr[9:2]];
    endfunction

    // Sampled at the falling edge, where inputs and outputs are both stable.
    always @(negedge clk) begin
        word_t expected;
        addr_t storeAddr;
        if (rst) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                outWrite[p].delete();
                outAddr[p].delete();
                outWdata[p].delete();
                pendData[p].delete();
                loadGranted[p] = 1'b0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (respValid[p]) begin
                    if (!loadGranted[p]) begin
                        errors++;
                        $display("Port %0d gave a response without a load granted before it",
                                 p);
                    end
                    if (pendData[p].size() == 0) begin
                        errors++;
                        $display("Port %0d gave a response with no load pending", p);
                    end else begin
                        expected = pendData[p].pop_front();
                        if (respData[p] !== expected) begin
                            errors++;
                            $display("Mismatch respData[%0d]: expected %08h, got %08h",
                                     p, expected, respData[p]);
                        end
                    end
                end else if (loadGranted[p]) begin
                    errors++;
                    $display("Port %0d gave no response one cycle after a load credit", p);
                end
                loadGranted[p] = 1'b0;

                // A credit is the grant, so the model follows grant order.
                if (creditReturn[p]) begin
                    credits++;
                    if (outWrite[p].size() == 0) begin
                        errors++;
                        $display("Port %0d returned a credit with no request outstanding", p);
                    end else if (outWrite[p].pop_front()) begin
                        storeAddr = outAddr[p].pop_front();
                        model[storeAddr[9:2]] = outWdata[p].pop_front();
                    end else begin
                        pendData[p].push_back(refLoad(outAddr[p].pop_front()));
                        void'(outWdata[p].pop_front());
                        loadGranted[p] = 1'b1;
                    end
                end

                if (reqValid[p]) begin
                    outWrite[p].push_back(reqWrite[p]);
                    outAddr[p].push_back(reqAddr[p]);
                    outWdata[p].push_back(reqWdata[p]);
                end
            end
        end
        drained = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (outWrite[p].size() != 0 || pendData[p].size() != 0 || loadGranted[p]) begin
                drained = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tbDataMem.sv
`timescale 1ns/1ps
`default_nettype none

module tbDataMem
    import dataMemPkg::*;
();

    localparam int WAIT_LIMIT  = 100;  // Cycles allowed for one credit.
    localparam int DRAIN_LIMIT = 300;  // Cycles allowed for all credits to return.

    logic  clk;
    logic  rst;
    logic  reqValid     [NUM_PORTS];
    logic  reqWrite     [NUM_PORTS];
    addr_t reqAddr      [NUM_PORTS];
    word_t reqWdata     [NUM_PORTS];
    logic  creditReturn [NUM_PORTS];
    logic  respValid    [NUM_PORTS];
    word_t respData     [NUM_PORTS];

    int          credits [NUM_PORTS];  // Credits held per port.
    int          sentTotal = 0;
    int          tbErrors  = 0;
    int          checkErrors;
    int          creditTotal;
    logic        drained;
    logic [31:0] lfsrState = 32'h9957;

    // Traffic drawn ahead of time, one list per port.
    logic  trafWrite [NUM_PORTS][$];
    addr_t trafAddr  [NUM_PORTS][$];
    word_t trafData  [NUM_PORTS][$];
    logic  trafGap   [NUM_PORTS][$];

    dataMemSubsystem u_dut (
        .clk          (clk),
        .rst          (rst),
        .reqValid     (reqValid),
        .reqWrite     (reqWrite),
        .reqAddr      (reqAddr),
        .reqWdata     (reqWdata),
        .creditReturn (creditReturn),
        .respValid    (respValid),
        .respData     (respData)
    );

    memChecker u_checker (
        .clk          (clk),
        .rst          (rst),
        .reqValid     (reqValid),
        .reqWrite     (reqWrite),
        .reqAddr      (reqAddr),
        .reqWdata     (reqWdata),
        .creditReturn (creditReturn),
        .respValid    (respValid),
        .respData     (respData),
        .errorCount   (checkErrors),
        .creditTotal  (creditTotal),
        .drained      (drained)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period.
    end

    // Each credit pulse gives one slot back to its requester.
    always @(negedge clk) begin
        if (!rst) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (creditReturn[p]) begin
                    credits[p]++;
                end
            end
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken.
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            value     = {value[30:0], feedback};
        end
        return value;
    endfunction

    task automatic sendReq(input int port, input logic write, input addr_t addr,
                           input word_t data);
        int waited;
        waited = 0;
        while (credits[port] == 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (credits[port] == 0) begin
            tbErrors++;
            $display("Timeout: port %0d waited %0d cycles for a credit", port, waited);
        end else begin
            reqValid[port] = 1'b1;
            reqWrite[port] = write;
            reqAddr[port]  = addr;
            reqWdata[port] = data;
            credits[port]--;
            sentTotal++;
            @(posedge clk);
            #1;
            reqValid[port] = 1'b0;
        end
    endtask

    function automatic logic allCreditsHome();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (credits[p] != QUEUE_DEPTH) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (!allCreditsHome() && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!allCreditsHome()) begin
            tbErrors++;
            $display("Timeout: credits did not all return within %0d cycles", DRAIN_LIMIT);
        end
        repeat (2) @(posedge clk);  // Last load answers one cycle after its credit.
        #1;
        if (!drained) begin
            tbErrors++;
            $display("Checker still holds outstanding requests after the queues drained");
        end
    endtask

    // Small word window so both ports hit the same words.
    task automatic drawTraffic(input int port, input int count, input bit loadsOnly);
        addr_t addr;
        for (int i = 0; i < count; i++) begin
            trafWrite[port].push_back(loadsOnly ? 1'b0 : 1'(randBits(1)));
            addr[31:10] = 22'(randBits(22));
            addr[9:6]   = 4'b0000;
            addr[5:2]   = 4'(randBits(4));
            addr[1:0]   = 2'(randBits(2));
            trafAddr[port].push_back(addr);
            trafData[port].push_back(randBits(32));
            trafGap[port].push_back(!loadsOnly && randBits(2) == '0);
        end
    endtask

    task automatic runTraffic(input int port);
        while (trafAddr[port].size() != 0) begin
            sendReq(port, trafWrite[port].pop_front(), trafAddr[port].pop_front(),
                    trafData[port].pop_front());
            if (trafGap[port].pop_front()) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    initial begin
        addr_t storeAddr;
        addr_t loadAddr;
        for (int p = 0; p < NUM_PORTS; p++) begin
            reqValid[p] = 1'b0;
            reqWrite[p] = 1'b0;
            reqAddr[p]  = '0;
            reqWdata[p] = '0;
            credits[p]  = QUEUE_DEPTH;
        end
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle after reset. Any credit or response here is flagged.
        repeat (8) @(posedge clk);
        #1;

        // Start-up contents, plus one word above the preloaded range.
        for (int w = 0; w < INIT_WORDS; w++) begin
            sendReq(0, 1'b0, addr_t'(w * 4), '0);
        end
        sendReq(0, 1'b0, addr_t'(200 * 4), '0);
        waitDrain();

        // Store then load on one port, upper and byte bits changed.
        for (int i = 0; i < 16; i++) begin
            storeAddr = randBits(32);
            sendReq(i % 2, 1'b1, storeAddr, randBits(32));
            loadAddr        = storeAddr;
            loadAddr[31:10] = 22'(randBits(22));
            loadAddr[1:0]   = 2'(randBits(2));
            sendReq(i % 2, 1'b0, loadAddr, '0);
        end
        waitDrain();

        // Port 1 reads what port 0 stored once the store's credit is back.
        for (int i = 0; i < 4; i++) begin
            storeAddr = randBits(32);
            sendReq(0, 1'b1, storeAddr, randBits(32));
            waitDrain();
            loadAddr        = storeAddr;
            loadAddr[31:10] = 22'(randBits(22));
            sendReq(1, 1'b0, loadAddr, '0);
        end
        waitDrain();

        // Full bursts on both ports.
        drawTraffic(0, QUEUE_DEPTH, 1'b1);
        drawTraffic(1, QUEUE_DEPTH, 1'b1);
        fork
            runTraffic(0);
            runTraffic(1);
        join
        waitDrain();

        // Mixed traffic from both ports at once.
        drawTraffic(0, 60, 1'b0);
        drawTraffic(1, 60, 1'b0);
        fork
            runTraffic(0);
            runTraffic(1);
        join
        waitDrain();

        if (sentTotal != creditTotal) begin
            tbErrors++;
            $display("Sent %0d requests but saw %0d credits", sentTotal, creditTotal);
        end
        $display("Error counts: checker %0d, testbench %0d", checkErrors, tbErrors);
        if (checkErrors == 0 && tbErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dataMemSubsystem.f
+incdir+include
hw/dataMemPkg.sv
hw/dataMemory.sv
hw/memArbiter.sv
hw/loadStoreQueue.sv
hw/dataMemSubsystem.sv
verif/memChecker.sv
verif/tbDataMem.sv

//--- runSim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failures.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tbDataMem \
    -f dataMemSubsystem.f -o simDataMem > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/simDataMem > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation exited with an error"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation reported failures"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
exit 0
